// ==== Bender.yml ====
package:
  name: pma

sources:
  - source/pmaCfgPkg.sv
  - source/pmaTypesPkg.sv
  - source/txSerializer.sv
  - source/rxSampler.sv
  - source/commaAligner.sv
  - source/pmaTop.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/pmaTb.sv

// ==== source/commaAligner.sv ====
`timescale 1ns/1ps
`default_nettype none

module commaAligner
  import pmaCfgPkg::*;
  import pmaTypesPkg::*;
#(
  parameter int LockCommas = 2
) (
  input  wire         bitRateClk,
  input  wire         rstN,
  input  wire symbolT rxWindow,
  input  wire         rxIdle,
  output symbolT      rxOut,
  output logic        rxValid,
  output logic        rxLocked,
  output logic        recoveredClk
);

  localparam int CountWidth = $clog2(LockCommas + 1);
  localparam bitCountT LastBit = bitCountT'(SymbolWidth - 1);
  localparam bitCountT HalfSymbol = bitCountT'(SymbolWidth / 2);

  alignStateT state;
  alignStateT stateNext;
  bitCountT bitCount;
  bitCountT bitCountNext;
  logic [CountWidth-1:0] commaCount;
  logic [CountWidth-1:0] commaCountNext;
  logic commaHit;
  logic wordEnd;
  logic validNext;

  assign commaHit = (rxWindow == CommaPos) || (rxWindow == CommaNeg);
  assign wordEnd = (bitCount == LastBit);  // Window holds a whole symbol.
  assign rxLocked = (state == Locked);
  assign validNext = rxLocked && wordEnd && (stateNext == Locked);

  always_comb begin
    stateNext      = state;
    commaCountNext = commaCount;
    bitCountNext   = wordEnd ? '0 : bitCount + 1'b1;
    if (rxIdle) begin
      stateNext      = Hunt;  // Line went quiet.
      commaCountNext = '0;
    end else begin
      unique case (state)
        Hunt: begin
          if (commaHit) begin
            bitCountNext   = '0;  // Phase taken from this comma.
            commaCountNext = 1'b1;
            stateNext      = (LockCommas > 1) ? Confirm : Locked;
          end
        end
        Confirm: begin
          if (commaHit && !wordEnd) begin
            stateNext      = Hunt;
            commaCountNext = '0;
          end else if (commaHit) begin
            commaCountNext = commaCount + 1'b1;
            if (int'(commaCount) + 1 >= LockCommas) begin
              stateNext = Locked;
            end
          end
        end
        Locked: begin
          if (commaHit && !wordEnd) begin
            stateNext      = Hunt;  // Comma moved, realign.
            commaCountNext = '0;
          end
        end
        default: stateNext = Hunt;
      endcase
    end
  end

  always_ff @(posedge bitRateClk or negedge rstN) begin
    if (!rstN) begin
      state        <= Hunt;
      bitCount     <= '0;
      commaCount   <= '0;
      rxValid      <= 1'b0;
      recoveredClk <= 1'b0;
    end else begin
      state      <= stateNext;
      bitCount   <= bitCountNext;
      commaCount <= commaCountNext;
      rxValid    <= validNext;
      // Rises with each word, falls at mid symbol.
      if (validNext) begin
        recoveredClk <= 1'b1;
      end else if (stateNext != Locked || bitCountNext == HalfSymbol) begin
        recoveredClk <= 1'b0;
      end
    end
  end

  always_ff @(posedge bitRateClk) begin
    if (validNext) begin
      rxOut <= rxWindow;
    end
  end

  validOnlyLocked: assert property (
    @(posedge bitRateClk) disable iff (!rstN)
    rxValid |-> rxLocked
  ) else $error("rxValid outside Locked");

  validSpacing: assert property (
    @(posedge bitRateClk) disable iff (!rstN)
    rxValid |=> !rxValid [*SymbolWidth-1]
  ) else $error("rxValid pulses closer than one symbol");

endmodule : commaAligner

`default_nettype wire

// ==== source/pmaCfgPkg.sv ====
`default_nettype none

package pmaCfgPkg;

  // Width of one 10b line symbol.
  localparam int SymbolWidth = 10;

  // K28.5 comma in transmission order.
  // Bit 0 is the first bit on the line (abcdei fghj, a first).
  localparam logic [SymbolWidth-1:0] CommaNeg = 10'h17C;  // RD- form.
  localparam logic [SymbolWidth-1:0] CommaPos = 10'h283;  // RD+ form.

endpackage : pmaCfgPkg

`default_nettype wire

// ==== source/pmaTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmaTop
  import pmaTypesPkg::*;
#(
  parameter int IdleBits   = 16,
  parameter int LockCommas = 2
) (
  input  wire         bitRateClk,
  input  wire         rstN,
  // MAC side, transmit.
  input  wire symbolT dataIn,
  input  wire         macDataEn,
  output logic        txLoad,
  // Line, transmit pair.
  output logic        txOutP,
  output logic        txOutN,
  // Line, receive pair.
  input  wire         rxInP,
  input  wire         rxInN,
  input  wire         rxPolarity,
  // MAC side, receive.
  output symbolT      rxOut,
  output logic        rxValid,
  output logic        rxLocked,
  output logic        recoveredClk
);

  symbolT rxWindow;
  logic   rxIdle;

  txSerializer txSerializerU (
    .bitRateClk (bitRateClk),
    .rstN       (rstN),
    .dataIn     (dataIn),
    .macDataEn  (macDataEn),
    .txLoad     (txLoad),
    .txOutP     (txOutP),
    .txOutN     (txOutN)
  );

  rxSampler #(
    .IdleBits (IdleBits)
  ) rxSamplerU (
    .bitRateClk (bitRateClk),
    .rstN       (rstN),
    .rxInP      (rxInP),
    .rxInN      (rxInN),
    .rxPolarity (rxPolarity),
    .rxWindow   (rxWindow),
    .rxIdle     (rxIdle)
  );

  // Word alignment on K28.5.
  commaAligner #(
    .LockCommas (LockCommas)
  ) commaAlignerU (
    .bitRateClk   (bitRateClk),
    .rstN         (rstN),
    .rxWindow     (rxWindow),
    .rxIdle       (rxIdle),
    .rxOut        (rxOut),
    .rxValid      (rxValid),
    .rxLocked     (rxLocked),
    .recoveredClk (recoveredClk)
  );

endmodule : pmaTop

`default_nettype wire

// ==== source/pmaTypesPkg.sv ====
`default_nettype none

package pmaTypesPkg;
  import pmaCfgPkg::*;

  typedef logic [SymbolWidth-1:0] symbolT;  // One line symbol, bit 0 first.

  typedef logic [3:0] bitCountT;  // Position 0 to 9.

  typedef logic [7:0] idleCountT;  // Run of equal P/N samples.

  typedef enum logic [1:0] {
    Hunt,
    Confirm,
    Locked
  } alignStateT;

  typedef enum logic {
    Idle,
    Active
  } txStateT;

endpackage : pmaTypesPkg

`default_nettype wire

// ==== source/rxSampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module rxSampler
  import pmaCfgPkg::*;
  import pmaTypesPkg::*;
#(
  parameter int IdleBits = 16
) (
  input  wire    bitRateClk,
  input  wire    rstN,
  input  wire    rxInP,
  input  wire    rxInN,
  input  wire    rxPolarity,
  output symbolT rxWindow,
  output logic   rxIdle
);

  localparam idleCountT IdleLimit = idleCountT'(IdleBits);

  logic sampleP;
  logic sampleN;
  logic samplePol;
  logic [SymbolWidth-2:0] history;
  idleCountT idleCount;

  always_ff @(posedge bitRateClk or negedge rstN) begin
    if (!rstN) begin
      sampleP   <= 1'b0;
      sampleN   <= 1'b0;
      samplePol <= 1'b0;
      idleCount <= '0;
    end else begin
      sampleP   <= rxInP;
      sampleN   <= rxInN;
      samplePol <= rxPolarity;
      if (rxInP != rxInN) begin
        idleCount <= '0;
      end else if (idleCount != IdleLimit) begin
        idleCount <= idleCount + 1'b1;  // Saturates at the limit.
      end
    end
  end

  // Newest bit on top, oldest in bit 0.
  assign rxWindow = {sampleP ^ samplePol, history};

  always_ff @(posedge bitRateClk) begin
    history <= rxWindow[SymbolWidth-1:1];
  end

  // Clears with the first unequal sample.
  assign rxIdle = (idleCount == IdleLimit);

  idleNeedsEqualPair: assert property (
    @(posedge bitRateClk) disable iff (!rstN)
    $rose(rxIdle) |-> (sampleP == sampleN)
  ) else $error("rxIdle rose on an active sample");

endmodule : rxSampler

`default_nettype wire

// ==== source/txSerializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module txSerializer
  import pmaCfgPkg::*;
  import pmaTypesPkg::*;
(
  input  wire         bitRateClk,
  input  wire         rstN,
  input  wire symbolT dataIn,
  input  wire         macDataEn,
  output logic        txLoad,
  output logic        txOutP,
  output logic        txOutN
);

  localparam bitCountT LastBit = bitCountT'(SymbolWidth - 1);

  txStateT  state;
  bitCountT bitCount;
  symbolT   shiftReg;

  // Slot boundary, symbol taken on the last bit.
  assign txLoad = (bitCount == LastBit);

  always_ff @(posedge bitRateClk or negedge rstN) begin
    if (!rstN) begin
      bitCount <= '0;
      state    <= Idle;
    end else begin
      if (txLoad) begin
        bitCount <= '0;
        state    <= macDataEn ? Active : Idle;  // Idle slot when MAC is quiet.
      end else begin
        bitCount <= bitCount + 1'b1;
      end
    end
  end

  always_ff @(posedge bitRateClk) begin
    if (txLoad) begin
      shiftReg <= dataIn;
    end else begin
      shiftReg <= shiftReg >> 1;  // LSB first.
    end
  end

  // Electrical idle pulls both legs low.
  assign txOutP = (state == Active) ? shiftReg[0] : 1'b0;
  assign txOutN = (state == Active) ? ~shiftReg[0] : 1'b0;

  txPairDiffers: assert property (
    @(posedge bitRateClk) disable iff (!rstN)
    (state == Active) |-> (txOutP != txOutN)
  ) else $error("txOutP and txOutN equal while active");

endmodule : txSerializer

`default_nettype wire

// ==== src.f ====
+incdir+verif
source/pmaCfgPkg.sv
source/pmaTypesPkg.sv
source/txSerializer.sv
source/rxSampler.sv
source/commaAligner.sv
source/pmaTop.sv
verif/pmaTb.sv

// ==== verif/pmaTbTasks.svh ====
`ifndef PMA_TB_TASKS_SVH
`define PMA_TB_TASKS_SVH

localparam int LoadTimeout = 20;
localparam int LockTimeout = 120;

task automatic abortTest();
  $display("test failed");
  $fatal(1);
endtask

task automatic checkSymbol(input string name, input symbolT got, input symbolT exp);
  if (got !== exp) begin
    $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    abortTest();
  end
endtask

task automatic checkBit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    abortTest();
  end
endtask

// Returns 1 ns after the edge that raised txLoad.
task automatic waitTxLoad();
  for (int n = 0; n < LoadTimeout; n++) begin
    @(posedge bitRateClk);
    #1;
    if (txLoad === 1'b1) return;
  end
  $display("timeout: txLoad did not pulse within %0d cycles", LoadTimeout);
  abortTest();
endtask

task automatic waitLockLevel(input logic level);
  for (int n = 0; n < LockTimeout; n++) begin
    @(negedge bitRateClk);
    if (rxLocked === level) return;
  end
  $display("timeout: rxLocked did not go to %0d within %0d cycles", level, LockTimeout);
  abortTest();
endtask

`endif

// ==== verif/pmaTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmaTb
  import pmaCfgPkg::*;
  import pmaTypesPkg::*;
();

  localparam int IdleBits    = 16;
  localparam int LockCommas  = 2;
  localparam int NumRows     = 5;
  localparam int MaxSym      = 10;
  localparam int MaxDelay    = 10;
  localparam int QuietCycles = 40;
  localparam symbolT LineLow  = '0;  // Idle slot as received.
  localparam symbolT LineHigh = '1;  // Idle slot through a swapped pair.

  logic   bitRateClk = 1'b0;
  logic   rstN       = 1'b0;
  symbolT dataIn     = '0;
  logic   macDataEn  = 1'b0;
  logic   rxInP      = 1'b0;
  logic   rxInN      = 1'b0;
  logic   rxPolarity = 1'b0;
  logic   txLoad;
  logic   txOutP;
  logic   txOutN;
  symbolT rxOut;
  logic   rxValid;
  logic   rxLocked;
  logic   recoveredClk;

  logic [MaxDelay-1:0] pLine = '0;
  logic [MaxDelay-1:0] nLine = '0;
  int   lineDelay = 0;
  logic lineInv   = 1'b0;

  // Stimulus table, one row per link session.
  symbolT            rowSym [NumRows][MaxSym];
  logic [MaxSym-1:0] rowEn [NumRows];  // Bit i enables symbol i.
  int                rowLen [NumRows];
  logic              rowInv [NumRows];
  int                rowDelay [NumRows];  // Negative means random.
  symbolT            rowExp [NumRows][MaxSym];
  int                rowExpLen [NumRows];

  symbolT rxWords [$];
  logic   sawLock    = 1'b0;
  logic   prevRecClk = 1'b0;
  int     loadGap    = -1;  // Cycles since the last txLoad.
  integer seed       = 32'hb734;

  `include "pmaTbTasks.svh"

  always #5 bitRateClk = ~bitRateClk;

  pmaTop #(
    .IdleBits   (IdleBits),
    .LockCommas (LockCommas)
  ) dut (
    .bitRateClk   (bitRateClk),
    .rstN         (rstN),
    .dataIn       (dataIn),
    .macDataEn    (macDataEn),
    .txLoad       (txLoad),
    .txOutP       (txOutP),
    .txOutN       (txOutN),
    .rxInP        (rxInP),
    .rxInN        (rxInN),
    .rxPolarity   (rxPolarity),
    .rxOut        (rxOut),
    .rxValid      (rxValid),
    .rxLocked     (rxLocked),
    .recoveredClk (recoveredClk)
  );

  // Loopback line with extra delay and optional P/N swap.
  always @(posedge bitRateClk) begin
    #1;
    pLine = {pLine[MaxDelay-2:0], txOutP};
    nLine = {nLine[MaxDelay-2:0], txOutN};
    rxInP = lineInv ? nLine[lineDelay] : pLine[lineDelay];
    rxInN = lineInv ? pLine[lineDelay] : nLine[lineDelay];
  end

  // Word capture, load strobe and recovered clock checks.
  always @(negedge bitRateClk) begin
    if (rstN) begin
      if (rxValid) rxWords.push_back(rxOut);
      if (rxLocked) sawLock = 1'b1;
      if (loadGap >= 0) checkBit("txLoad", txLoad, loadGap == SymbolWidth - 1);
      if (txLoad) begin
        loadGap = 0;
      end else if (loadGap >= 0) begin
        loadGap++;
      end
      checkBit("recoveredClk rise", recoveredClk && !prevRecClk, rxValid);
      if (!rxLocked) checkBit("recoveredClk", recoveredClk, 1'b0);
    end
    prevRecClk = recoveredClk;
  end

  task automatic fillTable();
    rowSym[0] = '{CommaNeg, CommaPos, 10'h155, 10'h2AA, 10'h0CC,
                  10'h333, 10'h1A5, 10'h25A, 10'h000, 10'h000};
    rowEn[0] = 10'h0FF;
    rowLen[0] = 8;
    rowInv[0] = 1'b0;
    rowDelay[0] = 0;
    rowExp[0] = '{10'h155, 10'h2AA, 10'h0CC, 10'h333, 10'h1A5,
                  10'h25A, LineLow, 10'h000, 10'h000, 10'h000};
    rowExpLen[0] = 7;
    rowSym[1] = '{CommaNeg, CommaNeg, 10'h169, 10'h296, 10'h155,
                  10'h333, 10'h000, 10'h000, 10'h000, 10'h000};
    rowEn[1] = 10'h03F;
    rowLen[1] = 6;
    rowInv[1] = 1'b1;
    rowDelay[1] = 3;
    rowExp[1] = '{10'h169, 10'h296, 10'h155, 10'h333, LineHigh,
                  10'h000, 10'h000, 10'h000, 10'h000, 10'h000};
    rowExpLen[1] = 5;
    rowSym[2] = '{CommaPos, CommaNeg, 10'h25A, 10'h1A5, 10'h0CC,
                  10'h2AA, 10'h000, 10'h000, 10'h000, 10'h000};
    rowEn[2] = 10'h03F;
    rowLen[2] = 6;
    rowInv[2] = 1'b0;
    rowDelay[2] = -1;
    rowExp[2] = '{10'h25A, 10'h1A5, 10'h0CC, 10'h2AA, LineLow,
                  10'h000, 10'h000, 10'h000, 10'h000, 10'h000};
    rowExpLen[2] = 5;
    rowSym[3] = '{CommaNeg, CommaPos, 10'h333, 10'h169, 10'h296,
                  10'h155, 10'h000, 10'h000, 10'h000, 10'h000};
    rowEn[3] = 10'h03F;
    rowLen[3] = 6;
    rowInv[3] = 1'b1;
    rowDelay[3] = -1;
    rowExp[3] = '{10'h333, 10'h169, 10'h296, 10'h155, LineHigh,
                  10'h000, 10'h000, 10'h000, 10'h000, 10'h000};
    rowExpLen[3] = 5;
    // Two idle slots mid row drop lock, then two commas relock.
    rowSym[4] = '{CommaNeg, CommaPos, 10'h155, 10'h000, 10'h000,
                  CommaNeg, CommaPos, 10'h2AA, 10'h1A5, 10'h000};
    rowEn[4] = 10'b01_1110_0111;
    rowLen[4] = 9;
    rowInv[4] = 1'b0;
    rowDelay[4] = 5;
    rowExp[4] = '{10'h155, LineLow, 10'h2AA, 10'h1A5, LineLow,
                  10'h000, 10'h000, 10'h000, 10'h000, 10'h000};
    rowExpLen[4] = 5;
  endtask

  initial begin : stimulus
    int prevDelay;
    fillTable();
    prevDelay = -1;
    repeat (2) @(posedge bitRateClk);
    #1;
    rstN = 1'b1;
    for (int c = 0; c < QuietCycles; c++) begin
      @(negedge bitRateClk);
      checkBit("txOutP", txOutP, 1'b0);
      checkBit("txOutN", txOutN, 1'b0);
      checkBit("rxLocked", rxLocked, 1'b0);
    end
    if (rxWords.size() != 0) begin
      $display("rxValid pulsed while the line was idle");
      abortTest();
    end
    for (int r = 0; r < NumRows; r++) begin
      @(negedge bitRateClk);
      if (rowDelay[r] < 0) begin
        lineDelay = (($random(seed) % MaxDelay) + MaxDelay) % MaxDelay;
        if (lineDelay == prevDelay) lineDelay = (lineDelay + 1) % MaxDelay;  // Force a change.
      end else begin
        lineDelay = rowDelay[r];
      end
      prevDelay = lineDelay;
      lineInv = rowInv[r];
      @(posedge bitRateClk);
      #1;
      rxPolarity = rowInv[r];
      rxWords.delete();
      sawLock = 1'b0;
      for (int i = 0; i < rowLen[r]; i++) begin
        waitTxLoad();
        dataIn    = rowSym[r][i];
        macDataEn = rowEn[r][i];
      end
      waitTxLoad();
      dataIn    = '0;
      macDataEn = 1'b0;
      waitLockLevel(1'b0);
      repeat (QuietCycles) @(posedge bitRateClk);  // No words may follow.
      #1;
      if (!sawLock) begin
        $display("row %0d: rxLocked never rose", r);
        abortTest();
      end
      if (rxWords.size() != rowExpLen[r]) begin
        $display("row %0d: %0d words on rxOut, expected %0d", r, rxWords.size(), rowExpLen[r]);
        abortTest();
      end
      for (int i = 0; i < rowExpLen[r]; i++) begin
        checkSymbol("rxOut", rxWords[i], rowExp[r][i]);
      end
    end
    $display("test passed");
    $finish;
  end

endmodule : pmaTb

`default_nettype wire
